// File: project.f
logic/ps2_kbd_pkg.sv
logic/ps2_clk_filter.sv
logic/ps2_frame_rx.sv
logic/key_mode_fsm.sv
logic/ship_cmd_decode.sv
logic/ps2_ship_ctrl_top.sv
tests/ps2_ship_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the fail message.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
	-f project.f \
	--top-module ps2_ship_ctrl_tb \
	-o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

// File: tests/ps2_ship_ctrl_tb.sv
// directed testbench; probes internal rx_done and ps2c_fall, needs filter_depth 3 or more
`timescale 1ns/1ps

module ps2_ship_ctrl_tb import ps2_kbd_pkg::*;
();

	localparam int filter_depth    = 8;                     // passed to the DUT
	localparam int half_period     = 20;                    // clk cycles per ps2c half
	localparam int settle_cycles   = 2 * filter_depth;      // idle high after each frame
	localparam int frame_wait      = 4 * filter_depth;      // limit for the end of a frame
	localparam int total_frames    = 24;                    // frames sent by all tests
	localparam int glitch_count    = 6;
	localparam int watchdog_cycles = total_frames * 11 * 2 * half_period + 2000;

	logic      clk;
	logic      reset;
	logic      ps2c;
	logic      ps2d;
	logic      key_valid;
	logic      upper_case;
	scan_t     scan_code;
	ship_cmd_t ship_cmd;
	seg7_t     hex_seg;

	int errors      = 0;
	int checks      = 0;
	int frames_done = 0;                                    // rx_done pulses seen
	int edges_seen  = 0;                                    // filtered falling edges
	int seed        = 32'hbcf6;

	logic [7:0] cap_code[$];                                // one entry per key_valid
	logic       cap_upper[$];
	logic [3:0] cap_cmd[$];
	logic [6:0] cap_seg[$];

	ps2_ship_ctrl_top #(
		.filter_depth (filter_depth)
	) UUT (
		.clk        (clk),
		.reset      (reset),
		.ps2c       (ps2c),
		.ps2d       (ps2d),
		.key_valid  (key_valid),
		.upper_case (upper_case),
		.scan_code  (scan_code),
		.ship_cmd   (ship_cmd),
		.hex_seg    (hex_seg)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;                             // 20 ns period
	end

	// sample mid cycle, all outputs settled
	always @(negedge clk)
	begin
		if (UUT.u_frame_rx.rx_done)
			frames_done++;
		if (UUT.u_clk_filter.ps2c_fall)
			edges_seen++;
		if (key_valid)
		begin
			cap_code.push_back(scan_code);
			cap_upper.push_back(upper_case);
			cap_cmd.push_back(ship_cmd);
			cap_seg.push_back(hex_seg);
		end
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired, the tests did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

	task automatic tick;
		@(posedge clk);
		#1;                                                 // drive just after the edge
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string msg);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
		end
	endtask

	task automatic clear_capture;
		cap_code.delete();
		cap_upper.delete();
		cap_cmd.delete();
		cap_seg.delete();
	endtask

	task automatic check_pulse_count(input int exp, input string msg);
		check_value(32'(cap_code.size()), 32'(exp), {msg, ": key_valid pulse count"});
	endtask

	task automatic check_pulse(input int idx, input logic [7:0] code, input logic upper,
		input logic [3:0] cmd, input logic [6:0] seg);
		if (idx >= cap_code.size())
		begin
			errors++;
			$display("key_valid pulse %0d never arrived, code %h expected", idx, code);
		end
		else
		begin
			check_value(32'(cap_code[idx]), 32'(code), $sformatf("pulse %0d scan_code", idx));
			check_value(32'(cap_upper[idx]), 32'(upper), $sformatf("pulse %0d upper_case", idx));
			check_value(32'(cap_cmd[idx]), 32'(cmd), $sformatf("pulse %0d ship_cmd", idx));
			check_value(32'(cap_seg[idx]), 32'(seg), $sformatf("pulse %0d hex_seg", idx));
		end
	endtask

	// start 0, data lsb first, odd parity, stop 1
	task automatic send_frame(input logic [7:0] code);
		logic [10:0] bits;
		int          start_count;
		int          waited;
		int          i;
		bits        = {1'b1, ~^code, code, 1'b0};
		start_count = frames_done;
		tick;                                               // back to the drive point
		for (i = 0; i < 11; i++)
		begin
			ps2d = bits[i];                                 // data moves while ps2c high
			repeat (half_period) tick;
			ps2c = 1'b0;
			repeat (half_period) tick;
			ps2c = 1'b1;
		end
		waited = 0;
		while (frames_done == start_count && waited < frame_wait)
		begin
			tick;
			waited++;
		end
		if (frames_done == start_count)
		begin
			errors++;
			$display("receiver never finished the frame carrying code %h", code);
		end
		ps2d = 1'b1;
		repeat (settle_cycles) tick;                        // filter back to high
	endtask

	task automatic send_glitch(input int len);
		ps2c = 1'b0;
		repeat (len) tick;                                  // shorter than the filter
		ps2c = 1'b1;
		repeat (settle_cycles) tick;
	endtask

	task automatic report_test(input int num, input string name, input int err_before);
		$display("test %0d %s finished with %0d errors", num, name, errors - err_before);
	endtask

	task automatic test_reset_state;
		int err_before;
		err_before = errors;
		repeat (3 * filter_depth) tick;                     // line idle high, no frame
		@(negedge clk);
		check_pulse_count(0, "reset");
		check_value(32'(edges_seen), 32'd0, "filtered edges after reset");
		check_value(32'(upper_case), 32'd0, "upper_case after reset");
		check_value(32'(scan_code), 32'h00, "scan_code after reset");
		check_value(32'(ship_cmd), 32'(cmd_none), "ship_cmd after reset");
		check_value(32'(hex_seg), 32'(7'b1101011), "hex_seg after reset");
		report_test(1, "reset state", err_before);
	endtask

	task automatic test_plain_key;
		int err_before;
		err_before = errors;
		clear_capture;
		send_frame(8'h1C);
		check_pulse_count(1, "make 1C");
		check_pulse(0, 8'h1C, 1'b0, cmd_left, 7'b1011111);
		send_frame(8'hF0);                                  // release is dropped
		send_frame(8'h1C);
		check_pulse_count(1, "break 1C");
		report_test(2, "plain key", err_before);
	endtask

	task automatic test_shift;
		int err_before;
		err_before = errors;
		clear_capture;
		send_frame(8'h12);                                  // left shift down
		send_frame(8'h1D);
		send_frame(8'hF0);
		send_frame(8'h1D);                                  // still shifted
		send_frame(8'hF0);
		send_frame(8'h12);                                  // shift up
		send_frame(8'h23);
		check_pulse_count(2, "shift sequence");
		check_pulse(0, 8'h1D, 1'b1, cmd_up, 7'b1111110);
		check_pulse(1, 8'h23, 1'b0, cmd_right, 7'b1111101);
		@(negedge clk);
		check_value(32'(upper_case), 32'd0, "upper_case after shift release");
		report_test(3, "shift", err_before);
	endtask

	task automatic test_caps;
		int err_before;
		err_before = errors;
		clear_capture;
		send_frame(8'h58);                                  // caps on, three more to leave
		@(negedge clk);
		check_value(32'(upper_case), 32'd1, "upper_case in caps mode");
		send_frame(8'hF0);
		send_frame(8'h58);                                  // release counts, two left
		send_frame(8'h1B);
		send_frame(8'h58);                                  // one left
		send_frame(8'hF0);
		send_frame(8'h58);                                  // zero, back to lower
		send_frame(8'h29);
		check_pulse_count(2, "caps sequence");
		check_pulse(0, 8'h1B, 1'b1, cmd_down, 7'b0111111);
		check_pulse(1, 8'h29, 1'b0, cmd_fire, 7'b1110111);
		report_test(4, "caps lock", err_before);
	endtask

	task automatic test_arrows;
		int err_before;
		err_before = errors;
		clear_capture;
		send_frame(8'h75);
		send_frame(8'h6B);
		send_frame(8'h72);
		send_frame(8'h74);
		send_frame(8'h15);                                  // q, not mapped
		check_pulse_count(5, "arrow keys");
		check_pulse(0, 8'h75, 1'b0, cmd_p2_up, 7'b1101011);
		check_pulse(1, 8'h6B, 1'b0, cmd_p2_left, 7'b1101011);
		check_pulse(2, 8'h72, 1'b0, cmd_p2_down, 7'b1101011);
		check_pulse(3, 8'h74, 1'b0, cmd_p2_right, 7'b1101011);
		check_pulse(4, 8'h15, 1'b0, cmd_none, 7'b1101011);
		report_test(5, "arrows and unmapped", err_before);
	endtask

	task automatic test_glitch;
		int err_before;
		int edges_before;
		int frames_before;
		int len;
		int n;
		err_before    = errors;
		edges_before  = edges_seen;
		frames_before = frames_done;
		clear_capture;
		for (n = 0; n < glitch_count; n++)
		begin
			len = 1 + int'($unsigned($random(seed)) % (filter_depth - 2));
			send_glitch(len);
		end
		check_value(32'(edges_seen), 32'(edges_before), "filtered edges from glitches");
		check_value(32'(frames_done), 32'(frames_before), "frames from glitches");
		check_pulse_count(0, "glitches");
		send_frame(8'h1C);                                  // receiver still aligned
		check_pulse_count(1, "frame after glitches");
		check_pulse(0, 8'h1C, 1'b0, cmd_left, 7'b1011111);
		report_test(6, "glitch rejection", err_before);
	endtask

	initial
	begin
		reset = 1'b1;
		ps2c  = 1'b1;                                       // idle bus
		ps2d  = 1'b1;
		repeat (10) tick;
		reset = 1'b0;

		test_reset_state;
		test_plain_key;
		test_shift;
		test_caps;
		test_arrows;
		test_glitch;

		$display("6 tests, %0d checks, %0d errors, %0d frames", checks, errors, frames_done);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: logic/ps2_ship_ctrl_top.sv
// keyboard front end top; single clock domain, ps2c and ps2d are assumed already synchronous to clk
`timescale 1ns/1ps

module ps2_ship_ctrl_top import ps2_kbd_pkg::*;
#(
	parameter int filter_depth = 8          // clock filter length, 2 or more
)
(
	input  logic      clk,
	input  logic      reset,
	input  logic      ps2c,                 // keyboard clock
	input  logic      ps2d,                 // keyboard data
	output logic      key_valid,            // one pulse per key for the game
	output logic      upper_case,
	output scan_t     scan_code,
	output ship_cmd_t ship_cmd,
	output seg7_t     hex_seg
);

	logic  ps2c_fall;                       // filtered clock edge
	logic  rx_done;                         // frame complete
	scan_t rx_byte;

	ps2_clk_filter #(
		.filter_depth (filter_depth)
	) u_clk_filter (
		.clk       (clk),
		.reset     (reset),
		.ps2c      (ps2c),
		.ps2c_fall (ps2c_fall)
	);

	ps2_frame_rx u_frame_rx (
		.clk       (clk),
		.reset     (reset),
		.ps2c_fall (ps2c_fall),
		.ps2d      (ps2d),
		.rx_done   (rx_done),
		.rx_byte   (rx_byte)
	);

	key_mode_fsm u_key_mode (
		.clk        (clk),
		.reset      (reset),
		.rx_done    (rx_done),
		.rx_byte    (rx_byte),
		.key_valid  (key_valid),
		.scan_code  (scan_code),
		.upper_case (upper_case)
	);

	ship_cmd_decode u_cmd_decode (
		.scan_code (scan_code),
		.ship_cmd  (ship_cmd),
		.hex_seg   (hex_seg)
	);

endmodule

// File: logic/ship_cmd_decode.sv
// scan code to ship command and seven-segment pattern; pure lookup, no register, case is ignored
`timescale 1ns/1ps

module ship_cmd_decode import ps2_kbd_pkg::*;
(
	input  scan_t     scan_code,
	output ship_cmd_t ship_cmd,
	output seg7_t     hex_seg               // active low
);

	always_comb
	begin
		case (scan_code)
			8'h1C:   ship_cmd = cmd_left;       // a
			8'h23:   ship_cmd = cmd_right;      // d
			8'h1B:   ship_cmd = cmd_down;       // s
			8'h1D:   ship_cmd = cmd_up;         // w
			8'h29:   ship_cmd = cmd_fire;       // space
			8'h75:   ship_cmd = cmd_p2_up;      // arrow keys for a second player
			8'h6B:   ship_cmd = cmd_p2_left;
			8'h72:   ship_cmd = cmd_p2_down;
			8'h74:   ship_cmd = cmd_p2_right;
			default: ship_cmd = cmd_none;       // unmapped
		endcase
	end

	always_comb
	begin
		case (ship_cmd)
			cmd_left:  hex_seg = 7'b1011111;    // segment f lit
			cmd_right: hex_seg = 7'b1111101;    // segment b lit
			cmd_down:  hex_seg = 7'b0111111;    // segment g lit
			cmd_up:    hex_seg = 7'b1111110;    // segment a lit
			cmd_fire:  hex_seg = 7'b1110111;    // segment d lit
			default:   hex_seg = 7'b1101011;    // idle pattern, arrows too
		endcase
	end

endmodule

// File: logic/key_mode_fsm.sv
// make/break/shift/caps tracking; no back-pressure, an unsampled key_valid pulse is lost
`timescale 1ns/1ps

module key_mode_fsm import ps2_kbd_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  rx_done,                  // new byte from receiver
	input  scan_t rx_byte,
	output logic  key_valid,                // one cycle per accepted key
	output scan_t scan_code,
	output logic  upper_case                // level, follows mode
);

	key_mode_t  mode_q;
	key_mode_t  mode_d;
	scan_t      shift_key_q;                // which shift opened shift mode
	scan_t      shift_key_d;
	logic [1:0] caps_cnt_q;                 // caps codes left before exit
	logic [1:0] caps_cnt_d;
	logic       is_shift;
	logic       is_caps;
	logic       is_break;

	assign is_shift = (rx_byte == code_lshift) || (rx_byte == code_rshift);
	assign is_caps  = (rx_byte == code_caps);
	assign is_break = (rx_byte == code_break);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			mode_q      <= mode_lower;
			shift_key_q <= 8'h00;
			caps_cnt_q  <= 2'd0;
		end
		else
		begin
			mode_q      <= mode_d;
			shift_key_q <= shift_key_d;
			caps_cnt_q  <= caps_cnt_d;
		end
	end

	always_comb
	begin
		mode_d      = mode_q;
		shift_key_d = shift_key_q;
		caps_cnt_d  = caps_cnt_q;
		key_valid   = 1'b0;
		upper_case  = 1'b0;

		case (mode_q)
			mode_lower:
			begin
				if (rx_done)
				begin
					if (is_shift)
					begin
						shift_key_d = rx_byte;              // remember left or right
						mode_d      = mode_shift;
					end
					else if (is_caps)
					begin
						caps_cnt_d = 2'(caps_toggles);
						mode_d     = mode_caps;
					end
					else if (is_break)
						mode_d = mode_lower_brk;
					else
						key_valid = 1'b1;                   // plain key
				end
			end

			mode_lower_brk:
			begin
				if (rx_done)
					mode_d = mode_lower;                    // released key, dropped
			end

			mode_shift:
			begin
				upper_case = 1'b1;
				if (rx_done)
				begin
					if (is_break)
						mode_d = mode_shift_brk;
					else if (!is_shift && !is_caps)
						key_valid = 1'b1;                   // shifted key
				end
			end

			mode_shift_brk:
			begin
				if (rx_done)
				begin
					if (rx_byte == shift_key_q)
						mode_d = mode_lower;                // shift released
					else
						mode_d = mode_shift;                // other key released
				end
			end

			mode_caps:
			begin
				upper_case = 1'b1;
				// Counter can reach zero on a break sequence; leave on the next cycle.
				if (caps_cnt_q == 2'd0)
					mode_d = mode_lower;
				if (rx_done)
				begin
					if (is_caps)
						caps_cnt_d = caps_cnt_q - 2'd1;
					else if (is_break)
						mode_d = mode_caps_brk;
					else if (!is_shift)
						key_valid = 1'b1;                   // caps key
				end
			end

			mode_caps_brk:
			begin
				if (rx_done)
				begin
					if (is_caps)
						caps_cnt_d = caps_cnt_q - 2'd1;     // caps release counts too
					mode_d = mode_caps;
				end
			end

			default:
				mode_d = mode_lower;
		endcase
	end

	assign scan_code = rx_byte;             // valid with key_valid

endmodule

// File: logic/ps2_frame_rx.sv
// PS/2 frame receiver; parity and stop bits are shifted in but never checked, rx_byte moves during a frame
`timescale 1ns/1ps

module ps2_frame_rx import ps2_kbd_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  ps2c_fall,                // filtered falling edge
	input  logic  ps2d,                     // keyboard data line
	output logic  rx_done,                  // one cycle at end of frame
	output scan_t rx_byte                   // data byte of the frame
);

	typedef enum logic
	{
		st_idle = 1'b0,                     // waiting for start bit
		st_recv = 1'b1                      // shifting in the frame
	} rx_state_t;

	rx_state_t   state_q;
	rx_state_t   state_d;
	logic [3:0]  bit_cnt_q;                 // bits still to come
	logic [3:0]  bit_cnt_d;
	logic [10:0] shift_q;                   // stop at top once done
	logic [10:0] shift_d;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state_q   <= st_idle;
			bit_cnt_q <= 4'd0;
			shift_q   <= 11'd0;             // scan code reads 00 after reset
		end
		else
		begin
			state_q   <= state_d;
			bit_cnt_q <= bit_cnt_d;
			shift_q   <= shift_d;
		end
	end

	always_comb
	begin
		state_d   = state_q;
		bit_cnt_d = bit_cnt_q;
		shift_d   = shift_q;
		rx_done   = 1'b0;

		case (state_q)
			st_idle:
			begin
				if (ps2c_fall)                          // start bit
				begin
					bit_cnt_d = 4'(frame_bits);
					state_d   = st_recv;
				end
			end

			st_recv:
			begin
				if (ps2c_fall)
				begin
					shift_d   = {ps2d, shift_q[10:1]};  // lsb first, shift right
					bit_cnt_d = bit_cnt_q - 4'd1;
				end
				if (bit_cnt_q == 4'd0)                  // stop bit already in
				begin
					rx_done = 1'b1;
					state_d = st_idle;
				end
			end

			default:
				state_d = st_idle;
		endcase
	end

	assign rx_byte = shift_q[8:1];          // d7 at bit 8, d0 at bit 1

endmodule

// File: logic/ps2_clk_filter.sv
// PS/2 clock glitch filter; filter_depth must be 2 or more, edges lag the line by filter_depth cycles
`timescale 1ns/1ps

module ps2_clk_filter
#(
	parameter int filter_depth = 8          // samples that must agree
)
(
	input  logic clk,
	input  logic reset,
	input  logic ps2c,                      // raw keyboard clock
	output logic ps2c_fall                  // one cycle per clean falling edge
);

	logic [filter_depth-1:0] filt_sr;       // newest sample at the top
	logic                    filt_lvl;      // debounced clock level
	logic                    all_ones;
	logic                    all_zeros;

	assign all_ones  = &filt_sr;
	assign all_zeros = ~|filt_sr;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			filt_sr  <= '0;
			filt_lvl <= 1'b0;
		end
		else
		begin
			filt_sr <= {ps2c, filt_sr[filter_depth-1:1]};   // shift right
			if (all_ones)
				filt_lvl <= 1'b1;                           // settled high
			else if (all_zeros)
				filt_lvl <= 1'b0;                           // settled low
		end
	end

	// level about to drop
	assign ps2c_fall = filt_lvl & all_zeros;

endmodule

// File: logic/ps2_kbd_pkg.sv
// shared PS/2 keyboard types; scan codes are set 2, parity of a frame is never checked
package ps2_kbd_pkg;

	typedef logic [7:0] scan_t;             // one keyboard scan code
	typedef logic [6:0] seg7_t;             // active low, segment g at bit 6

	localparam scan_t code_break  = 8'hF0;  // break prefix
	localparam scan_t code_lshift = 8'h12;  // left shift
	localparam scan_t code_rshift = 8'h59;  // right shift
	localparam scan_t code_caps   = 8'h58;  // caps lock

	// bits after the start bit: 8 data, parity, stop
	localparam int frame_bits = 10;

	// further caps codes needed to leave caps mode
	localparam int caps_toggles = 3;

	typedef enum logic [3:0]
	{
		cmd_none     = 4'd0,                // no mapped key
		cmd_left     = 4'd1,                // a
		cmd_right    = 4'd2,                // d
		cmd_down     = 4'd3,                // s
		cmd_up       = 4'd4,                // w
		cmd_fire     = 4'd5,                // space
		cmd_p2_up    = 4'd6,                // up arrow
		cmd_p2_left  = 4'd7,                // left arrow
		cmd_p2_down  = 4'd8,                // down arrow
		cmd_p2_right = 4'd9                 // right arrow
	} ship_cmd_t;

	typedef enum logic [2:0]
	{
		mode_lower     = 3'd0,              // idle, lower case keys
		mode_lower_brk = 3'd1,              // drop code after F0
		mode_shift     = 3'd2,              // shift held
		mode_shift_brk = 3'd3,              // F0 seen while shifted
		mode_caps      = 3'd4,              // caps lock on
		mode_caps_brk  = 3'd5               // F0 seen in caps mode
	} key_mode_t;

endpackage
